/* Makefile */
SOURCES := $(filter-out +%,$(shell cat all.f))

.PHONY: run clean

run: obj_dir/Vtb_lsu
	./obj_dir/Vtb_lsu > sim.log 2>&1; cat sim.log
	@! grep -q "Simulation FAILED" sim.log
	@grep -q "Simulation PASSED" sim.log

obj_dir/Vtb_lsu: all.f $(SOURCES)
	verilator --binary --timing --assert --top-module tb_lsu -f all.f -o Vtb_lsu

clean:
	rm -rf obj_dir sim.log

/* all.f */
hw/lsu_cfg_pkg.sv
hw/riscv_isa_pkg.sv
hw/lsu_request_decode.sv
hw/data_bank.sv
hw/lsu_load_format.sv
hw/lsu_top.sv
verif/tb_clock_gen.sv
verif/tb_lsu.sv

/* hw/data_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module data_bank #(
  parameter int BANK_DEPTH = lsu_cfg_pkg::DEFAULT_BANK_DEPTH
) (
  input  logic                              clk,
  input  logic [$clog2(BANK_DEPTH)-1:0]     word_addr,
  input  logic                              we,
  input  logic [lsu_cfg_pkg::LANE_W-1:0]    wdata,
  input  logic                              rd_en,
  output logic [lsu_cfg_pkg::LANE_W-1:0]    rd_data
);

  import lsu_cfg_pkg::*;

  logic [LANE_W-1:0] mem [BANK_DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[word_addr] <= wdata;
    end
  end

  // output register holds the last read
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[word_addr];
    end
  end

  // decoder sends one request per cycle
  a_no_rw_overlap: assert property (@(posedge clk) !(we && rd_en));

endmodule

`default_nettype wire

/* hw/lsu_cfg_pkg.sv */
`default_nettype none

package lsu_cfg_pkg;

  // word size, fixed by the ISA
  parameter int XLEN = 32;

  // data memory is split into byte lanes
  parameter int NUM_LANES = 4;
  parameter int LANE_W = 8;

  // byte offset bits within a word
  parameter int OFFSET_W = 2;

  // entries per bank unless the top level overrides it
  parameter int DEFAULT_BANK_DEPTH = 256;

endpackage

`default_nettype wire

/* hw/lsu_load_format.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_format (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic                                                   rd_en,
  input  riscv_isa_pkg::mem_width_e                              load_width,
  input  logic [lsu_cfg_pkg::OFFSET_W-1:0]                       byte_offset,
  input  logic [lsu_cfg_pkg::NUM_LANES-1:0][lsu_cfg_pkg::LANE_W-1:0] rd_data,
  output logic [lsu_cfg_pkg::XLEN-1:0]                           lsu_result,
  output logic                                                   load_valid
);

  import lsu_cfg_pkg::*;
  import riscv_isa_pkg::*;

  mem_width_e          width_q;
  logic [OFFSET_W-1:0] offset_q;
  logic                loaded_q;
  logic [LANE_W-1:0]   sel_byte;
  logic [2*LANE_W-1:0] sel_half;
  logic [XLEN-1:0]     fmt_data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_valid <= 1'b0;
      loaded_q   <= 1'b0;
    end else begin
      load_valid <= rd_en;
      if (rd_en) begin
        loaded_q <= 1'b1;
      end
    end
  end

  // pending load info, lines up with bank output next cycle
  always_ff @(posedge clk) begin
    if (rd_en) begin
      width_q  <= load_width;
      offset_q <= byte_offset;
    end
  end

  assign sel_byte = rd_data[offset_q];
  assign sel_half = {rd_data[{offset_q[1], 1'b1}], rd_data[{offset_q[1], 1'b0}]};

  always_comb begin
    case (width_q)
      MW_B:    fmt_data = {{(XLEN-LANE_W){sel_byte[LANE_W-1]}}, sel_byte};
      MW_H:    fmt_data = {{(XLEN-2*LANE_W){sel_half[2*LANE_W-1]}}, sel_half};
      MW_W:    fmt_data = rd_data;  // lanes already little-endian
      MW_BU:   fmt_data = {{(XLEN-LANE_W){1'b0}}, sel_byte};
      MW_HU:   fmt_data = {{(XLEN-2*LANE_W){1'b0}}, sel_half};
      default: fmt_data = '0;
    endcase
  end

  // bank regs and captured fields hold, so the result holds too
  assign lsu_result = loaded_q ? fmt_data : '0;

  a_valid_width: assert property (@(posedge clk) disable iff (!rst_n)
    load_valid |-> (width_q inside {MW_B, MW_H, MW_W, MW_BU, MW_HU}));

endmodule

`default_nettype wire

/* hw/lsu_request_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_request_decode #(
  parameter int BANK_DEPTH = lsu_cfg_pkg::DEFAULT_BANK_DEPTH
) (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  riscv_isa_pkg::lsu_op_e                                 lsu_op,
  input  riscv_isa_pkg::mem_width_e                              funct3,
  input  logic [lsu_cfg_pkg::XLEN-1:0]                           exu_result,
  input  logic [lsu_cfg_pkg::XLEN-1:0]                           src2,
  output logic [$clog2(BANK_DEPTH)-1:0]                          word_addr,
  output logic [lsu_cfg_pkg::NUM_LANES-1:0]                      byte_we,
  output logic [lsu_cfg_pkg::NUM_LANES-1:0][lsu_cfg_pkg::LANE_W-1:0] lane_wdata,
  output logic                                                   rd_en,
  output riscv_isa_pkg::mem_width_e                              load_width,
  output logic [lsu_cfg_pkg::OFFSET_W-1:0]                       byte_offset,
  output logic                                                   access_fault
);

  import lsu_cfg_pkg::*;
  import riscv_isa_pkg::*;

  localparam int AW = $clog2(BANK_DEPTH);

  logic                 is_load;
  logic                 is_store;
  logic                 width_legal;
  logic                 aligned;
  logic                 fault;
  logic [NUM_LANES-1:0] size_mask;
  logic [OFFSET_W-1:0]  offset;

  assign offset    = exu_result[OFFSET_W-1:0];
  assign word_addr = exu_result[AW+OFFSET_W-1:OFFSET_W];  // upper bits wrap

  assign is_load  = (lsu_op == LSU_LOAD);
  assign is_store = (lsu_op == LSU_STORE);

  always_comb begin
    size_mask = '0;
    aligned   = 1'b0;
    case (funct3)
      MW_B, MW_BU: begin
        size_mask = NUM_LANES'(1);
        aligned   = 1'b1;
      end
      MW_H, MW_HU: begin
        size_mask = NUM_LANES'(3);
        aligned   = ~offset[0];
      end
      MW_W: begin
        size_mask = '1;
        aligned   = (offset == '0);
      end
      default: ;
    endcase
  end

  // stores have no unsigned forms
  assign width_legal = is_store ? (funct3 inside {MW_B, MW_H, MW_W})
                                : (funct3 inside {MW_B, MW_H, MW_W, MW_BU, MW_HU});

  assign fault = (is_load | is_store) & ~(width_legal & aligned);

  assign rd_en   = is_load & ~fault;
  assign byte_we = (is_store & ~fault) ? (size_mask << offset) : '0;

  // replicate store data so any enabled lane sees its byte
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      case (funct3)
        MW_H:    lane_wdata[i] = src2[LANE_W*(i%2) +: LANE_W];
        MW_W:    lane_wdata[i] = src2[LANE_W*i +: LANE_W];
        default: lane_wdata[i] = src2[LANE_W-1:0];
      endcase
    end
  end

  assign load_width  = funct3;
  assign byte_offset = offset;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      access_fault <= 1'b0;
    end else begin
      access_fault <= fault;  // one-cycle pulse
    end
  end

  a_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_op inside {LSU_NONE, LSU_LOAD, LSU_STORE});

  a_no_we_on_load: assert property (@(posedge clk) disable iff (!rst_n)
    is_load |-> (byte_we == '0));

endmodule

`default_nettype wire

/* hw/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
  parameter int BANK_DEPTH = lsu_cfg_pkg::DEFAULT_BANK_DEPTH
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  riscv_isa_pkg::lsu_op_e        lsu_op,
  input  riscv_isa_pkg::mem_width_e     funct3,
  input  logic [lsu_cfg_pkg::XLEN-1:0]  exu_result,
  input  logic [lsu_cfg_pkg::XLEN-1:0]  src2,
  output logic [lsu_cfg_pkg::XLEN-1:0]  lsu_result,
  output logic                          load_valid,
  output logic                          access_fault
);

  import lsu_cfg_pkg::*;
  import riscv_isa_pkg::*;

  logic [$clog2(BANK_DEPTH)-1:0]       word_addr;
  logic [NUM_LANES-1:0]                byte_we;
  logic [NUM_LANES-1:0][LANE_W-1:0]    lane_wdata;
  logic                                rd_en;
  mem_width_e                          load_width;
  logic [OFFSET_W-1:0]                 byte_offset;
  logic [NUM_LANES-1:0][LANE_W-1:0]    rd_data;

  lsu_request_decode #(
    .BANK_DEPTH   (BANK_DEPTH)
  ) u_decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_op       (lsu_op),
    .funct3       (funct3),
    .exu_result   (exu_result),
    .src2         (src2),
    .word_addr    (word_addr),
    .byte_we      (byte_we),
    .lane_wdata   (lane_wdata),
    .rd_en        (rd_en),
    .load_width   (load_width),
    .byte_offset  (byte_offset),
    .access_fault (access_fault)
  );

  // one bank per byte lane
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_bank
    data_bank #(
      .BANK_DEPTH (BANK_DEPTH)
    ) u_bank (
      .clk        (clk),
      .word_addr  (word_addr),
      .we         (byte_we[i]),
      .wdata      (lane_wdata[i]),
      .rd_en      (rd_en),
      .rd_data    (rd_data[i])
    );
  end

  lsu_load_format u_format (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_en        (rd_en),
    .load_width   (load_width),
    .byte_offset  (byte_offset),
    .rd_data      (rd_data),
    .lsu_result   (lsu_result),
    .load_valid   (load_valid)
  );

endmodule

`default_nettype wire

/* hw/riscv_isa_pkg.sv */
`default_nettype none

package riscv_isa_pkg;

  // load/store request kind from execute
  typedef enum logic [1:0] {
    LSU_NONE  = 2'd0,
    LSU_LOAD  = 2'd1,
    LSU_STORE = 2'd2
  } lsu_op_e;

  // access width, encoded exactly as funct3
  typedef enum logic [2:0] {
    MW_B  = 3'd0,  // lb / sb
    MW_H  = 3'd1,  // lh / sh
    MW_W  = 3'd2,  // lw / sw
    MW_BU = 3'd4,  // lbu
    MW_HU = 3'd5   // lhu
  } mem_width_e;

endpackage

`default_nettype wire

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;  // lands after same-edge reads
  end

endmodule

`default_nettype wire

/* verif/tb_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

  import lsu_cfg_pkg::*;
  import riscv_isa_pkg::*;

  localparam int BANK_DEPTH = 256;
  localparam int MEM_BYTES  = BANK_DEPTH * NUM_LANES;
  localparam int MA_W       = $clog2(MEM_BYTES);
  localparam int TIMEOUT    = 10;

  logic            clk;
  logic            rst_n;
  lsu_op_e         lsu_op;
  mem_width_e      funct3;
  logic [XLEN-1:0] exu_result;
  logic [XLEN-1:0] src2;
  logic [XLEN-1:0] lsu_result;
  logic            load_valid;
  logic            access_fault;

  logic [LANE_W-1:0] model_mem [MEM_BYTES];  // byte-addressed reference memory
  int                mismatch_errors;
  int                other_errors;
  integer            seed;

  tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(3)) u_clk_gen (.clk(clk), .rst_n(rst_n));

  lsu_top #(
    .BANK_DEPTH   (BANK_DEPTH)
  ) UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_op       (lsu_op),
    .funct3       (funct3),
    .exu_result   (exu_result),
    .src2         (src2),
    .lsu_result   (lsu_result),
    .load_valid   (load_valid),
    .access_fault (access_fault)
  );

  // higher address bits alias onto the array
  function automatic logic [MA_W-1:0] byte_index(input logic [XLEN-1:0] addr);
    return MA_W'(addr % MEM_BYTES);
  endfunction

  function automatic void model_store(input logic [XLEN-1:0] addr, input mem_width_e w,
                                      input logic [XLEN-1:0] data);
    logic [MA_W-1:0] base;
    int              n;
    base = byte_index(addr);
    case (w)
      MW_B:    n = 1;
      MW_H:    n = 2;
      default: n = 4;
    endcase
    for (int k = 0; k < n; k++) begin
      model_mem[base + MA_W'(k)] = data[8*k +: 8];  // little-endian
    end
  endfunction

  function automatic logic [XLEN-1:0] model_load(input logic [XLEN-1:0] addr,
                                                 input mem_width_e w);
    logic [MA_W-1:0] base;
    logic [7:0]      b0;
    logic [7:0]      b1;
    base = byte_index(addr);
    b0   = model_mem[base];
    b1   = model_mem[base + MA_W'(1)];
    case (w)
      MW_B:    return {{24{b0[7]}}, b0};
      MW_BU:   return {24'h0, b0};
      MW_H:    return {{16{b1[7]}}, b1, b0};
      MW_HU:   return {16'h0, b1, b0};
      default: return {model_mem[base + MA_W'(3)], model_mem[base + MA_W'(2)], b1, b0};
    endcase
  endfunction

  // random address inside the array, aligned for the width
  function automatic logic [XLEN-1:0] pick_addr(input mem_width_e w);
    logic [XLEN-1:0] a;
    a = $random(seed);
    a = a % MEM_BYTES;
    case (w)
      MW_W:        a[1:0] = 2'b00;
      MW_H, MW_HU: a[0] = 1'b0;
      default: ;
    endcase
    return a;
  endfunction

  task automatic check_value(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input string what);
    assert (got === exp) else begin
      mismatch_errors++;
      $display("mismatch at %0t: %s got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input bit ok, input string what);
    assert (ok) else begin
      other_errors++;
      $display("error at %0t: %s", $time, what);
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    if (mismatch_errors + other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    other_errors++;
    $display("timeout at %0t: %s never happened", $time, what);
    finish_run();
  endtask

  task automatic drive_request(input lsu_op_e op, input logic [XLEN-1:0] addr,
                               input mem_width_e w, input logic [XLEN-1:0] data);
    @(negedge clk);
    lsu_op     = op;
    funct3     = w;
    exu_result = addr;
    src2       = data;
  endtask

  // retires the request, then waits for load_valid or access_fault
  task automatic wait_for_response(input string what);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      lsu_op = LSU_NONE;
      cycles++;
    end while (!(load_valid || access_fault) && cycles < TIMEOUT);
    if (!(load_valid || access_fault)) begin
      fail_timeout($sformatf("a response to %s", what));
    end else begin
      check_flag(cycles == 1, $sformatf("%s answered after %0d cycles, not 1", what, cycles));
    end
  endtask

  task automatic check_fault_pulse(input string what);
    check_flag(access_fault && !load_valid, $sformatf("%s did not fault cleanly", what));
    @(negedge clk);
    check_flag(!access_fault, $sformatf("access_fault held too long after %s", what));
  endtask

  task automatic store_req(input logic [XLEN-1:0] addr, input mem_width_e w,
                           input logic [XLEN-1:0] data, input bit want_fault);
    string what;
    what = $sformatf("store %s at %08h", w.name(), addr);
    drive_request(LSU_STORE, addr, w, data);
    if (want_fault) begin
      wait_for_response(what);
      check_fault_pulse(what);
    end else begin
      @(negedge clk);
      lsu_op = LSU_NONE;
      check_flag(!access_fault && !load_valid, $sformatf("%s gave a response", what));
      model_store(addr, w, data);
    end
  endtask

  task automatic load_req(input logic [XLEN-1:0] addr, input mem_width_e w,
                          input bit want_fault);
    logic [XLEN-1:0] exp;
    string           what;
    what = $sformatf("load %s at %08h", w.name(), addr);
    exp  = model_load(addr, w);
    drive_request(LSU_LOAD, addr, w, $random(seed));
    wait_for_response(what);
    if (want_fault) begin
      check_fault_pulse(what);
    end else begin
      check_flag(load_valid && !access_fault, $sformatf("%s gave no clean load_valid", what));
      check_value(lsu_result, exp, what);
    end
  endtask

  task automatic check_reset_state();
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < TIMEOUT) begin
      @(negedge clk);
      check_flag(!load_valid && !access_fault, "load_valid or access_fault high at reset");
      check_value(lsu_result, '0, "lsu_result at reset");
      n++;
    end
    if (rst_n !== 1'b1) begin
      fail_timeout("reset release");
    end
  endtask

  task automatic fill_memory();
    logic [XLEN-1:0] word;
    for (int i = 0; i < BANK_DEPTH; i++) begin
      word = (XLEN'(i) * 32'h0101_0101) ^ 32'ha5c3_3c5a;
      store_req(XLEN'(i * NUM_LANES), MW_W, word, 1'b0);
    end
  endtask

  task automatic test_word_rw();
    logic [XLEN-1:0] addr;
    repeat (16) begin
      addr = pick_addr(MW_W);
      store_req(addr, MW_W, $random(seed), 1'b0);
      load_req(addr, MW_W, 1'b0);
    end
  endtask

  task automatic test_subword();
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] data;
    for (int n = 0; n < 4; n++) begin
      base = pick_addr(MW_W);
      for (int off = 0; off < 4; off++) begin
        data    = $random(seed);
        data[7] = off[0];  // sign bit on odd lanes
        store_req(base + off, MW_B, data, 1'b0);
        load_req(base + off, MW_B, 1'b0);
        load_req(base + off, MW_BU, 1'b0);
        load_req(base, MW_W, 1'b0);  // other lanes untouched
      end
      for (int off = 0; off < 4; off += 2) begin
        data     = $random(seed);
        data[15] = (off == 2);
        store_req(base + off, MW_H, data, 1'b0);
        load_req(base + off, MW_H, 1'b0);
        load_req(base + off, MW_HU, 1'b0);
        load_req(base, MW_W, 1'b0);
      end
    end
  endtask

  task automatic test_faults();
    logic [XLEN-1:0] base;
    base = pick_addr(MW_W);
    load_req(base + 1, MW_H, 1'b1);
    load_req(base + 3, MW_HU, 1'b1);
    load_req(base + 1, MW_W, 1'b1);
    load_req(base + 2, MW_W, 1'b1);
    load_req(base + 3, MW_W, 1'b1);
    store_req(base + 1, MW_H, $random(seed), 1'b1);
    store_req(base + 3, MW_H, $random(seed), 1'b1);
    store_req(base + 2, MW_W, $random(seed), 1'b1);
    store_req(base + 1, MW_W, $random(seed), 1'b1);
    store_req(base, MW_BU, $random(seed), 1'b1);  // no unsigned stores
    store_req(base, MW_HU, $random(seed), 1'b1);
    load_req(base, MW_W, 1'b0);
  endtask

  task automatic test_streaming();
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
    logic [XLEN-1:0] exp_q [$];
    mem_width_e      w;
    for (int n = 0; n < 4; n++) begin
      addr = pick_addr(MW_W);
      data = $random(seed);
      drive_request(LSU_STORE, addr, MW_W, data);
      model_store(addr, MW_W, data);
      drive_request(LSU_LOAD, addr, MW_W, '0);
      check_flag(!access_fault, "streamed store faulted");
      wait_for_response("load right after store");
      check_value(lsu_result, model_load(addr, MW_W), "load right after store");
    end
    // one load per cycle, results must come out in order
    for (int k = 0; k <= 8; k++) begin
      @(negedge clk);
      if (k > 0) begin
        check_flag(load_valid, "streamed load has no load_valid");
        check_value(lsu_result, exp_q.pop_front(), "streamed load");
      end
      if (k < 8) begin
        case (k % 4)
          0:       w = MW_W;
          1:       w = MW_B;
          2:       w = MW_HU;
          default: w = MW_H;
        endcase
        addr = pick_addr(w);
        exp_q.push_back(model_load(addr, w));
        lsu_op     = LSU_LOAD;
        funct3     = w;
        exu_result = addr;
      end else begin
        lsu_op = LSU_NONE;
      end
    end
  endtask

  task automatic test_addr_wrap();
    logic [XLEN-1:0] addr;
    for (int n = 1; n < 4; n++) begin
      addr = pick_addr(MW_W);
      store_req(addr + n * MEM_BYTES, MW_W, $random(seed), 1'b0);
      load_req(addr, MW_W, 1'b0);
    end
    addr = pick_addr(MW_H);
    store_req(addr, MW_H, $random(seed), 1'b0);
    load_req(addr | 32'h8000_0000, MW_HU, 1'b0);
    load_req(addr + 32'h0001_0000, MW_H, 1'b0);
  endtask

  initial begin
    seed            = 32'h89d7_3142;
    mismatch_errors = 0;
    other_errors    = 0;
    lsu_op          = LSU_NONE;
    funct3          = MW_W;
    exu_result      = '0;
    src2            = '0;
    check_reset_state();
    fill_memory();  // banks power up unknown
    test_word_rw();
    test_subword();
    test_faults();
    test_streaming();
    test_addr_wrap();
    finish_run();
  end

endmodule

`default_nettype wire
